//--- hw/conv_pkg.sv
package conv_pkg;

  // ========================================
  // Sizes and delays
  // ========================================

  localparam int N_LANE    = 4;   // Output channels.
  localparam int LANE_W    = 2;
  localparam int FIL       = 3;
  localparam int LWIDTH    = 5;
  localparam int LINE_LEN  = 16;  // Widest image.
  localparam int LINE_W    = 4;
  localparam int FACCUM    = 8;
  localparam int ACC_DEPTH = 196; // 14 x 14 feature pixels.
  localparam int ACC_WIDTH = 20;
  localparam int PROD_W    = 17;  // 9-bit pixel times 8-bit weight.
  localparam int D_CONV    = 2;
  localparam int D_ACCUM   = 1;
  localparam int SHIFT     = 4;

  // ========================================
  // Types
  // ========================================

  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } ctrl_reg;

  typedef enum logic [1:0] {
    CORE_WAIT,
    CORE_NETWORK,
    CORE_INPUT,
    CORE_OUTPUT
  } core_state_t;

  typedef struct packed {
    logic [1:0]        spare;
    logic [LANE_W-1:0] lane;
    logic [3:0]        tap;   // Raster order in the window.
    logic signed [7:0] value;
  } weight_word_t;

  typedef struct packed {
    logic [7:0] spare;
    logic [7:0] value;
  } pixel_word_t;

  // Network state reads weights, input state reads pixels.
  typedef union packed {
    weight_word_t weight;
    pixel_word_t  pixel;
  } in_word_t;

  typedef logic [FIL*FIL-1:0][7:0] window_t;
  typedef logic signed [ACC_WIDTH-1:0] acc_t;
  typedef acc_t [N_LANE-1:0] lane_acc_t;
  typedef logic [N_LANE-1:0][7:0] feat_t;

endpackage

//--- hw/conv_ctrl.sv
`timescale 1ns/100ps

module conv_ctrl (
  input  logic                        clk,
  input  logic                        xrst,
  input  conv_pkg::ctrl_reg           in_ctrl,
  input  conv_pkg::in_word_t          in_word,
  input  conv_pkg::core_state_t       core_state,
  input  logic [conv_pkg::LWIDTH-1:0] img_size,
  input  logic                        first_input,
  input  logic                        last_input,
  output logic                        pix_valid,
  output logic [conv_pkg::LWIDTH-1:0] conv_x,
  output logic [conv_pkg::LWIDTH-1:0] conv_y,
  output logic                        weight_we,
  output logic                        feat_we,
  output logic                        feat_rst,
  output logic [conv_pkg::FACCUM-1:0] feat_waddr,
  output logic [conv_pkg::FACCUM-1:0] feat_raddr,
  output conv_pkg::ctrl_reg           rd_ctrl,
  output logic [conv_pkg::LWIDTH-1:0] fea_size
);
  import conv_pkg::*;

  typedef enum logic {S_WAIT, S_ACTIVE} state_t;

  state_t            r_state;
  core_state_t       r_core_state;
  logic [LWIDTH-1:0] r_img_size;
  logic [LWIDTH-1:0] r_fea_size;
  logic [LWIDTH-1:0] r_x;
  logic [LWIDTH-1:0] r_y;
  logic              r_first_input;
  logic              r_planes_done;
  logic              r_wait_back;
  logic              r_conv_valid;
  logic              r_plane_end;
  logic [FACCUM-1:0] r_waddr;
  logic [FACCUM-1:0] r_raddr;
  logic              r_we_d   [D_CONV];
  logic              r_rst_d  [D_CONV];
  logic [FACCUM-1:0] r_addr_d [D_CONV];
  ctrl_reg           r_rd_d   [D_ACCUM+1];
  logic [LWIDTH-1:0] lim;
  logic              x_end;
  logic              y_end;
  logic              job_start;
  logic              last_pix;
  logic              rd_go;
  ctrl_reg           rd_now;

  // ========================================
  // Job FSM and counters
  // ========================================

  assign job_start = r_state == S_WAIT && in_ctrl.start;
  assign pix_valid = r_state == S_ACTIVE && core_state == CORE_INPUT && in_ctrl.valid;
  assign weight_we = core_state == CORE_NETWORK && in_ctrl.valid
                     && in_word.weight.tap < 4'(FIL*FIL);

  assign lim      = (r_core_state == CORE_OUTPUT) ? r_fea_size : r_img_size;
  assign x_end    = r_x == lim - 1'b1;
  assign y_end    = r_y == lim - 1'b1;
  assign last_pix = pix_valid && x_end && y_end;

  assign conv_x   = r_x;
  assign conv_y   = r_y;
  assign fea_size = r_fea_size;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state      <= S_WAIT;
      r_core_state <= CORE_WAIT;
    end else begin
      r_core_state <= core_state;
      if (job_start)
        r_state <= S_ACTIVE;
      else if (r_rd_d[D_ACCUM].stop)
        r_state <= S_WAIT;  // Ends with out_ctrl.stop.
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_img_size <= '0;
      r_fea_size <= '0;
    end else if (job_start) begin
      r_img_size <= img_size;
      r_fea_size <= img_size - LWIDTH'(FIL - 1);
    end
  end

  // Image raster while loading, feature raster while reading.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_x <= '0;
      r_y <= '0;
    end else if (r_state == S_WAIT) begin
      r_x <= '0;
      r_y <= '0;
    end else if (pix_valid || rd_go) begin
      if (x_end) begin
        r_x <= '0;
        r_y <= y_end ? '0 : r_y + 1'b1;
      end else begin
        r_x <= r_x + 1'b1;
      end
    end
  end

  // ========================================
  // Feature memory write
  // ========================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_conv_valid  <= 1'b0;
      r_plane_end   <= 1'b0;
      r_first_input <= 1'b0;
      r_planes_done <= 1'b0;
    end else begin
      r_conv_valid  <= pix_valid && r_x >= LWIDTH'(FIL - 1) && r_y >= LWIDTH'(FIL - 1);
      r_plane_end   <= last_pix;
      r_first_input <= first_input;
      if (job_start)
        r_planes_done <= 1'b0;
      else if (last_pix && last_input)
        r_planes_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      r_waddr <= '0;
    else if (job_start || r_plane_end)
      r_waddr <= '0;
    else if (r_conv_valid)
      r_waddr <= r_waddr + 1'b1;
  end

  // Matches the multiply-add latency of the lanes.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < D_CONV; i++) begin
        r_we_d[i]  <= 1'b0;
        r_rst_d[i] <= 1'b0;
      end
    end else begin
      r_we_d[0]  <= r_conv_valid;
      r_rst_d[0] <= r_conv_valid && r_first_input;
      for (int i = 1; i < D_CONV; i++) begin
        r_we_d[i]  <= r_we_d[i-1];
        r_rst_d[i] <= r_rst_d[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    r_addr_d[0] <= r_waddr;
    for (int i = 1; i < D_CONV; i++)
      r_addr_d[i] <= r_addr_d[i-1];
  end

  assign feat_we    = r_we_d[D_CONV-1];
  assign feat_rst   = r_rst_d[D_CONV-1];
  assign feat_waddr = r_addr_d[D_CONV-1];

  // ========================================
  // Read pass
  // ========================================

  assign rd_go = r_state == S_ACTIVE && r_core_state == CORE_OUTPUT
                 && r_planes_done && !r_wait_back;

  always_comb begin
    rd_now.start = rd_go && r_x == '0 && r_y == '0;
    rd_now.valid = rd_go;
    rd_now.stop  = rd_go && x_end && y_end;
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      r_wait_back <= 1'b0;
    else if (job_start)
      r_wait_back <= 1'b0;
    else if (rd_now.stop)
      r_wait_back <= 1'b1;  // Hold until the host starts again.
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      r_raddr <= '0;
    else if (job_start)
      r_raddr <= '0;
    else if (rd_go)
      r_raddr <= rd_now.stop ? '0 : r_raddr + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i <= D_ACCUM; i++)
        r_rd_d[i] <= '0;
    end else begin
      r_rd_d[0] <= rd_now;
      for (int i = 1; i <= D_ACCUM; i++)
        r_rd_d[i] <= r_rd_d[i-1];
    end
  end

  assign feat_raddr = r_raddr;
  assign rd_ctrl    = r_rd_d[D_ACCUM-1];  // Lines up with the memory data.

endmodule

//--- hw/window_gen.sv
`timescale 1ns/100ps

module window_gen (
  input  logic                        clk,
  input  logic                        xrst,
  input  logic                        pix_valid,
  input  logic [7:0]                  pixel,
  input  logic [conv_pkg::LWIDTH-1:0] conv_x,
  input  logic [conv_pkg::LWIDTH-1:0] conv_y,
  output logic                        win_valid,
  output conv_pkg::window_t           window
);
  import conv_pkg::*;

  logic [7:0]        r_line0 [LINE_LEN];  // Row y-1.
  logic [7:0]        r_line1 [LINE_LEN];  // Row y-2.
  logic [7:0]        r_win   [FIL][FIL];
  logic [7:0]        col     [FIL];
  logic [LINE_W-1:0] idx;

  assign idx = conv_x[LINE_W-1:0];

  // Newest column, oldest row first.
  assign col[0] = r_line1[idx];
  assign col[1] = r_line0[idx];
  assign col[2] = pixel;

  always_ff @(posedge clk) begin
    if (pix_valid) begin
      r_line1[idx] <= r_line0[idx];
      r_line0[idx] <= pixel;
      for (int r = 0; r < FIL; r++) begin
        for (int c = 0; c < FIL - 1; c++)
          r_win[r][c] <= r_win[r][c+1];
        r_win[r][FIL-1] <= col[r];
      end
    end
  end

  // Window is complete once two rows and two columns are behind.
  always_ff @(posedge clk) begin
    if (!xrst)
      win_valid <= 1'b0;
    else
      win_valid <= pix_valid && conv_x >= LWIDTH'(FIL - 1) && conv_y >= LWIDTH'(FIL - 1);
  end

  always_comb begin
    for (int r = 0; r < FIL; r++)
      for (int c = 0; c < FIL; c++)
        window[r*FIL+c] = r_win[r][c];
  end

endmodule

//--- hw/conv_lane.sv
`timescale 1ns/100ps

module conv_lane (
  input  logic                        clk,
  input  logic                        xrst,
  input  logic [conv_pkg::LANE_W-1:0] lane_id,
  input  logic                        weight_we,
  input  conv_pkg::in_word_t          weight_word,
  input  logic                        win_valid,
  input  conv_pkg::window_t           window,
  input  logic                        feat_we,
  input  logic                        feat_rst,
  input  logic [conv_pkg::FACCUM-1:0] feat_waddr,
  input  logic [conv_pkg::FACCUM-1:0] feat_raddr,
  output conv_pkg::acc_t              feat_rdata
);
  import conv_pkg::*;

  logic signed [7:0]        r_weight [FIL*FIL];
  logic signed [PROD_W-1:0] r_prod   [FIL*FIL];
  logic                     r_prod_valid;
  acc_t                     r_sum;
  acc_t                     sum;
  acc_t                     r_mem    [ACC_DEPTH];

  // ========================================
  // Weights
  // ========================================

  always_ff @(posedge clk) begin
    if (weight_we && weight_word.weight.lane == lane_id)
      r_weight[weight_word.weight.tap] <= weight_word.weight.value;
  end

  // ========================================
  // Multiply-add tree
  // ========================================

  always_ff @(posedge clk) begin
    if (win_valid)
      for (int t = 0; t < FIL*FIL; t++)
        r_prod[t] <= $signed({1'b0, window[t]}) * r_weight[t];
  end

  always_comb begin
    sum = '0;
    for (int t = 0; t < FIL*FIL; t++)
      sum = sum + r_prod[t];
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      r_prod_valid <= 1'b0;
    else
      r_prod_valid <= win_valid;
  end

  always_ff @(posedge clk) begin
    if (r_prod_valid)
      r_sum <= sum;
  end

  // ========================================
  // Feature accumulation
  // ========================================

  always_ff @(posedge clk) begin
    if (feat_we) begin
      if (feat_rst)
        r_mem[feat_waddr] <= r_sum;  // First plane.
      else
        r_mem[feat_waddr] <= r_mem[feat_waddr] + r_sum;
    end
    feat_rdata <= r_mem[feat_raddr];
  end

endmodule

//--- hw/feat_drain.sv
`timescale 1ns/100ps

module feat_drain (
  input  logic                clk,
  input  logic                xrst,
  input  conv_pkg::ctrl_reg   rd_ctrl,
  input  conv_pkg::lane_acc_t lane_data,
  output conv_pkg::ctrl_reg   out_ctrl,
  output conv_pkg::feat_t     out_feat
);
  import conv_pkg::*;

  acc_t  scaled [N_LANE];
  feat_t clamped;

  // Scale, then ReLU and saturate to a byte.
  always_comb begin
    for (int i = 0; i < N_LANE; i++) begin
      scaled[i] = $signed(lane_data[i]) >>> SHIFT;
      if (scaled[i] < 0)
        clamped[i] = 8'd0;
      else if (scaled[i] > 255)
        clamped[i] = 8'd255;
      else
        clamped[i] = scaled[i][7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      out_ctrl <= '0;
    else
      out_ctrl <= rd_ctrl;
  end

  always_ff @(posedge clk) begin
    if (rd_ctrl.valid)
      out_feat <= clamped;  // All channels leave together.
  end

endmodule

//--- hw/conv_top.sv
`timescale 1ns/100ps

module conv_top (
  input  logic                        clk,
  input  logic                        xrst,
  input  conv_pkg::ctrl_reg           in_ctrl,
  input  conv_pkg::in_word_t          in_word,
  input  conv_pkg::core_state_t       core_state,
  input  logic [conv_pkg::LWIDTH-1:0] img_size,
  input  logic                        first_input,
  input  logic                        last_input,
  output conv_pkg::ctrl_reg           out_ctrl,
  output conv_pkg::feat_t             out_feat,
  output logic [conv_pkg::LWIDTH-1:0] fea_size
);
  import conv_pkg::*;

  logic              pix_valid;
  logic [LWIDTH-1:0] conv_x;
  logic [LWIDTH-1:0] conv_y;
  logic              weight_we;
  logic              feat_we;
  logic              feat_rst;
  logic [FACCUM-1:0] feat_waddr;
  logic [FACCUM-1:0] feat_raddr;
  ctrl_reg           rd_ctrl;
  logic              win_valid;
  window_t           window;
  lane_acc_t         lane_data;

  conv_ctrl u_ctrl (
    .clk         (clk),
    .xrst        (xrst),
    .in_ctrl     (in_ctrl),
    .in_word     (in_word),
    .core_state  (core_state),
    .img_size    (img_size),
    .first_input (first_input),
    .last_input  (last_input),
    .pix_valid   (pix_valid),
    .conv_x      (conv_x),
    .conv_y      (conv_y),
    .weight_we   (weight_we),
    .feat_we     (feat_we),
    .feat_rst    (feat_rst),
    .feat_waddr  (feat_waddr),
    .feat_raddr  (feat_raddr),
    .rd_ctrl     (rd_ctrl),
    .fea_size    (fea_size)
  );

  window_gen u_win (
    .clk       (clk),
    .xrst      (xrst),
    .pix_valid (pix_valid),
    .pixel     (in_word.pixel.value),
    .conv_x    (conv_x),
    .conv_y    (conv_y),
    .win_valid (win_valid),
    .window    (window)
  );

  // One lane per output channel, all fed the same window.
  for (genvar i = 0; i < N_LANE; i++) begin : g_lane
    conv_lane u_lane (
      .clk         (clk),
      .xrst        (xrst),
      .lane_id     (LANE_W'(i)),
      .weight_we   (weight_we),
      .weight_word (in_word),
      .win_valid   (win_valid),
      .window      (window),
      .feat_we     (feat_we),
      .feat_rst    (feat_rst),
      .feat_waddr  (feat_waddr),
      .feat_raddr  (feat_raddr),
      .feat_rdata  (lane_data[i])
    );
  end

  feat_drain u_drain (
    .clk       (clk),
    .xrst      (xrst),
    .rd_ctrl   (rd_ctrl),
    .lane_data (lane_data),
    .out_ctrl  (out_ctrl),
    .out_feat  (out_feat)
  );

endmodule

//--- dv/conv_tb.sv
`timescale 1ns/100ps

module conv_tb;
  import conv_pkg::*;

  localparam int CASE_DEPTH = 256;

  logic              clk = 1'b0;
  logic              xrst;
  ctrl_reg           in_ctrl;
  in_word_t          in_word;
  core_state_t       core_state;
  logic [LWIDTH-1:0] img_size;
  logic              first_input;
  logic              last_input;
  ctrl_reg           out_ctrl;
  feat_t             out_feat;
  logic [LWIDTH-1:0] fea_size;

  logic [31:0] cases [CASE_DEPTH];
  int          pos;
  int          limit;
  int          cycles;
  int          checks;
  int          errors;
  bit          reading;  // Set while out_ctrl may move.

  conv_top dut (.*);

  initial begin
    forever #20 clk = ~clk;
  end

  // ========================================
  // Checks and clocking
  // ========================================

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Advances to the next falling edge. Outside the read pass out_ctrl stays zero.
  task automatic tick();
    @(negedge clk);
    if (!reading)
      check("out_ctrl", 32'(out_ctrl), 32'd0);
  endtask

  // Bus words of all jobs, found by walking the job headers.
  function automatic int count_words();
    int idx;
    int total;
    int size;
    int planes;
    int nw;
    idx   = 0;
    total = 0;
    while (idx < CASE_DEPTH && cases[idx][31:28] == 4'h1) begin
      size   = int'(cases[idx][23:16]);
      planes = int'(cases[idx][15:8]);
      nw     = int'(cases[idx][7:0]);
      total += nw + planes * size * size + (size - 2) * (size - 2);
      idx   += 1 + nw + planes * ((size * size + 3) / 4) + (size - 2) * (size - 2);
    end
    return total;
  endfunction

  // ========================================
  // One job
  // ========================================

  task automatic run_job();
    int size;
    int planes;
    int nw;
    int npix;
    int nout;
    int k;
    bit done;
    size   = int'(cases[pos][23:16]);
    planes = int'(cases[pos][15:8]);
    nw     = int'(cases[pos][7:0]);
    npix   = size * size;
    nout   = (size - 2) * (size - 2);
    pos++;

    img_size      = LWIDTH'(size);
    in_ctrl.start = 1'b1;
    tick();
    in_ctrl.start = 1'b0;
    check("fea_size", 32'(fea_size), 32'(size - 2));

    core_state = CORE_NETWORK;
    for (int i = 0; i < nw; i++) begin
      in_word       = 16'({cases[pos][17:16], cases[pos][11:8], cases[pos][7:0]});
      in_ctrl.valid = 1'b1;
      tick();
      pos++;
    end
    in_ctrl.valid = 1'b0;

    core_state = CORE_INPUT;
    for (int p = 0; p < planes; p++) begin
      first_input = p == 0;
      last_input  = p == planes - 1;
      for (int i = 0; i < npix; i++) begin
        in_ctrl.valid = 1'b0;
        repeat ($urandom % 3) tick();
        in_word       = 16'(cases[pos + i / 4][31 - 8 * (i % 4) -: 8]);
        in_ctrl.valid = 1'b1;
        tick();
      end
      in_ctrl.valid = 1'b0;
      pos += (npix + 3) / 4;
    end

    core_state = CORE_OUTPUT;
    reading    = 1'b1;
    k          = 0;
    done       = 1'b0;
    while (!done) begin
      tick();
      if (out_ctrl.valid) begin
        check("out_feat", out_feat, cases[pos + k]);
        check("out_ctrl.start", 32'(out_ctrl.start), 32'(k == 0));
        check("out_ctrl.stop", 32'(out_ctrl.stop), 32'(k == nout - 1));
        done = out_ctrl.stop;
        k++;
      end else begin
        check("out_ctrl", 32'(out_ctrl), 32'd0);
      end
    end
    check("valid count", 32'(k), 32'(nout));
    pos += nout;
    reading    = 1'b0;
    core_state = CORE_WAIT;
    repeat (3) tick();
  endtask

  // ========================================
  // Run
  // ========================================

  initial begin
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    $display("Timeout: the jobs did not finish within %0d cycles", limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(60));
    xrst        = 1'b0;
    in_ctrl     = '0;
    in_word     = '0;
    core_state  = CORE_WAIT;
    img_size    = '0;
    first_input = 1'b0;
    last_input  = 1'b0;
    reading     = 1'b0;
    pos         = 0;
    for (int i = 0; i < CASE_DEPTH; i++)
      cases[i] = '0;
    $readmemh("dv/conv_cases.txt", cases);
    limit = 4 * count_words() + 200;
    repeat (16) tick();
    xrst = 1'b1;
    repeat (2) tick();
    while (pos < CASE_DEPTH && cases[pos][31:28] == 4'h1)
      run_job();
    if (pos == 0) begin
      errors++;
      $display("No jobs found in dv/conv_cases.txt");
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- dv/conv_cases.txt
// Job 10SS_PPNN: image size SS, PP planes, NN weight words 200L_0TVV (lane L, tap T, value VV).
// Then pixels four per word, first in the top byte, then one word per output, lane 3 on top.

// 5x5 image, one plane, every weight loaded.
1005_0124
2000_0000 2000_0100 2000_0200 2000_0300 2000_0410 2000_0500 2000_0600 2000_0700 2000_0800
2001_0010 2001_0100 2001_0200 2001_0300 2001_0400 2001_0500 2001_0600 2001_0700 2001_0800
2002_0000 2002_0100 2002_0200 2002_0300 2002_0400 2002_0500 2002_0600 2002_0700 2002_0820
2003_0000 2003_01F0 2003_0200 2003_0300 2003_0400 2003_0500 2003_0600 2003_0710 2003_0800
00081018 20303840 48506068 70788090 98A0A8B0 C0C8D0D8 E0000000
60E00038 60F00840 60FF1048 60FF3068 60FF3870 60FF4078 60FF6098 60FF68A0 60FF70A8

// 4x4 image, three planes summed, weights kept.
1004_0300
00010203 10111213 20212223 30313233
05050505 05050505 05050505 05050505
00000000 08080808 10101010 18181818
306E051E 3070061F 309E1D36 30A01E37

// 8x8 image, lane 3 reloaded so that its sums go negative.
1008_0109
2003_0020 2003_0100 2003_0200 2003_0300 2003_04E0 2003_0500 2003_0600 2003_0700 2003_0800
00010203 04050607 10111213 14151617 20212223 24252627 30313233 34353637
40414243 44454647 50515253 54555657 60616263 64656667 70717273 74757677
00440011 00460112 00480213 004A0314 004C0415 004E0516
00641021 00661122 00681223 006A1324 006C1425 006E1526
00842031 00862132 00882233 008A2334 008C2435 008E2536
00A43041 00A63142 00A83243 00AA3344 00AC3445 00AE3546
00C44051 00C64152 00C84253 00CA4354 00CC4455 00CE4556
00E45061 00E65162 00E85263 00EA5364 00EC5465 00EE5566

// End of jobs.
00000000

//--- compile.f
hw/conv_pkg.sv
hw/conv_ctrl.sv
hw/window_gen.sv
hw/conv_lane.sv
hw/feat_drain.sv
hw/conv_top.sv
dv/conv_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = conv_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
CASES    = dv/conv_cases.txt
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(CASES)
	./$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
